//--- decode_unit.sv
module decode_unit (
  input  isa_pkg::instr_t   instruction,
  output pipe_pkg::ctrl_t   ctrl,
  output isa_pkg::reg_idx_t rn,
  output isa_pkg::reg_idx_t rm,
  output isa_pkg::reg_idx_t rd,
  output isa_pkg::word_t    offset
);

  logic [10:0] opcode;
  logic        is_addi;

  assign opcode  = instruction[isa_pkg::opcode_lsb +: 11];
  assign is_addi = instruction[isa_pkg::addi_opcode_lsb +: 10] == isa_pkg::opcode_addi;

  always_comb begin
    ctrl = '0;                       // Unknown encodings stay a bubble
    if (is_addi) begin
      ctrl.alu_op    = pipe_pkg::alu_add;
      ctrl.alu_src   = 1'b1;
      ctrl.reg_write = 1'b1;
    end else begin
      case (opcode)
        isa_pkg::opcode_add: begin
          ctrl.alu_op    = pipe_pkg::alu_add;
          ctrl.reg_write = 1'b1;
        end
        isa_pkg::opcode_sub: begin
          ctrl.alu_op    = pipe_pkg::alu_sub;
          ctrl.reg_write = 1'b1;
        end
        isa_pkg::opcode_and: begin
          ctrl.alu_op    = pipe_pkg::alu_and;
          ctrl.reg_write = 1'b1;
        end
        isa_pkg::opcode_orr: begin
          ctrl.alu_op    = pipe_pkg::alu_orr;
          ctrl.reg_write = 1'b1;
        end
        isa_pkg::opcode_ldur: begin
          ctrl.alu_src    = 1'b1;    // Address is base plus offset
          ctrl.mem_read   = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
        end
        isa_pkg::opcode_stur: begin
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign rd = instruction[isa_pkg::rd_lsb +: 5];
  assign rn = instruction[isa_pkg::rn_lsb +: 5];
  // Stores read their data register from the Rd field
  assign rm = instruction[isa_pkg::reg2loc_bit] ? rd : instruction[isa_pkg::rm_lsb +: 5];

  assign offset = is_addi ?
                  {52'b0, instruction[isa_pkg::imm12_lsb +: 12]} :
                  {{55{instruction[isa_pkg::dt_addr_lsb + 8]}},
                   instruction[isa_pkg::dt_addr_lsb +: 9]};

endmodule

//--- execute_stage.sv
module execute_stage (
  input  logic               CLOCK,
  input  logic               reset,
  input  pipe_pkg::id_ex_t   id_ex,
  input  pipe_pkg::fwd_sel_t fwd_a,
  input  pipe_pkg::fwd_sel_t fwd_b,
  input  isa_pkg::word_t     wb_value,
  output isa_pkg::word_t     mem_address,
  output isa_pkg::word_t     mem_write_data,
  output logic               mem_read,
  output logic               mem_write,
  output isa_pkg::reg_idx_t  mem_rd,
  output logic               mem_reg_write,
  output logic               mem_to_reg
);

  isa_pkg::word_t operand_a;
  isa_pkg::word_t operand_b;
  isa_pkg::word_t alu_b;
  isa_pkg::word_t alu_result;

  function automatic isa_pkg::word_t forward(pipe_pkg::fwd_sel_t sel,
                                             isa_pkg::word_t reg_value);
    case (sel)
      pipe_pkg::from_mem: return mem_address;  // Registered ALU result
      pipe_pkg::from_wb:  return wb_value;
      default:            return reg_value;
    endcase
  endfunction

  always_comb begin
    operand_a = forward(fwd_a, id_ex.rn_data);
    operand_b = forward(fwd_b, id_ex.rm_data);
    alu_b     = id_ex.ctrl.alu_src ? id_ex.offset : operand_b;
    case (id_ex.ctrl.alu_op)
      pipe_pkg::alu_add: alu_result = operand_a + alu_b;
      pipe_pkg::alu_sub: alu_result = operand_a - alu_b;
      pipe_pkg::alu_and: alu_result = operand_a & alu_b;
      default:           alu_result = operand_a | alu_b;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      mem_read      <= 1'b0;
      mem_write     <= 1'b0;
      mem_reg_write <= 1'b0;
    end else begin
      mem_read      <= id_ex.ctrl.mem_read;
      mem_write     <= id_ex.ctrl.mem_write;
      mem_reg_write <= id_ex.ctrl.reg_write;
    end
  end

  always_ff @(posedge CLOCK) begin
    mem_address    <= alu_result;
    mem_write_data <= operand_b;               // Store data sees forwarding too
    mem_rd         <= id_ex.rd;
    mem_to_reg     <= id_ex.ctrl.mem_to_reg;
  end

  mem_strobes_exclusive: assert property (@(posedge CLOCK) disable iff (reset)
    !(mem_read && mem_write));

endmodule

//--- hazard_unit.sv
module hazard_unit (
  input  isa_pkg::reg_idx_t  id_rn,
  input  isa_pkg::reg_idx_t  id_rm,
  input  isa_pkg::reg_idx_t  ex_rn,
  input  isa_pkg::reg_idx_t  ex_rm,
  input  isa_pkg::reg_idx_t  ex_rd,
  input  logic               ex_mem_read,
  input  isa_pkg::reg_idx_t  mem_rd,
  input  logic               mem_reg_write,
  input  isa_pkg::reg_idx_t  wb_rd,
  input  logic               wb_reg_write,
  output logic               stall,
  output pipe_pkg::fwd_sel_t fwd_a,
  output pipe_pkg::fwd_sel_t fwd_b
);

  logic load_rd_live;

  // Newer MEM result wins over the WB result
  function automatic pipe_pkg::fwd_sel_t select_fwd(isa_pkg::reg_idx_t src);
    if (mem_reg_write && mem_rd != isa_pkg::zero_reg && mem_rd == src) begin
      return pipe_pkg::from_mem;
    end
    if (wb_reg_write && wb_rd != isa_pkg::zero_reg && wb_rd == src) begin
      return pipe_pkg::from_wb;
    end
    return pipe_pkg::from_reg;
  endfunction

  assign load_rd_live = ex_mem_read && ex_rd != isa_pkg::zero_reg;
  assign stall        = load_rd_live && (ex_rd == id_rn || ex_rd == id_rm);  // Load-use

  always_comb begin
    fwd_a = select_fwd(ex_rn);
    fwd_b = select_fwd(ex_rm);
  end

endmodule

//--- isa_pkg.sv
package isa_pkg;

  typedef logic [63:0] word_t;     // Register and memory data
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam reg_idx_t zero_reg = 5'd31;  // XZR

  // Opcodes of the supported subset
  localparam logic [10:0] opcode_add  = 11'b10001011000;
  localparam logic [10:0] opcode_sub  = 11'b11001011000;
  localparam logic [10:0] opcode_and  = 11'b10001010000;
  localparam logic [10:0] opcode_orr  = 11'b10101010000;
  localparam logic [10:0] opcode_ldur = 11'b11111000010;
  localparam logic [10:0] opcode_stur = 11'b11111000000;
  localparam logic [9:0]  opcode_addi = 10'b1001000100;  // I-type, 10-bit opcode

  localparam word_t pc_step = 64'd4;

  // Instruction field positions
  localparam int rd_lsb          = 0;
  localparam int rn_lsb          = 5;
  localparam int imm12_lsb       = 10;   // ADDI immediate
  localparam int dt_addr_lsb     = 12;   // D-type 9-bit offset
  localparam int rm_lsb          = 16;
  localparam int opcode_lsb      = 21;
  localparam int addi_opcode_lsb = 22;
  localparam int reg2loc_bit     = 28;   // Set for D-type and ADDI

endpackage

//--- legv8_cpu.sv
module legv8_cpu (
  input  logic            CLOCK,
  input  logic            reset,
  input  isa_pkg::instr_t instruction,
  input  isa_pkg::word_t  mem_read_data,
  output isa_pkg::word_t  pc,
  output isa_pkg::word_t  mem_address,
  output isa_pkg::word_t  mem_write_data,
  output logic            mem_read,
  output logic            mem_write
);

  logic               stall;
  pipe_pkg::if_id_t   if_id_d;
  pipe_pkg::if_id_t   if_id;
  pipe_pkg::id_ex_t   id_ex_d;
  pipe_pkg::id_ex_t   id_ex;
  pipe_pkg::ctrl_t    id_ctrl;
  isa_pkg::reg_idx_t  id_rn;
  isa_pkg::reg_idx_t  id_rm;
  isa_pkg::reg_idx_t  id_rd;
  isa_pkg::word_t     id_offset;
  isa_pkg::word_t     id_rn_data;
  isa_pkg::word_t     id_rm_data;
  pipe_pkg::fwd_sel_t fwd_a;
  pipe_pkg::fwd_sel_t fwd_b;
  isa_pkg::reg_idx_t  mem_rd;
  logic               mem_reg_write;
  logic               mem_to_reg;
  isa_pkg::reg_idx_t  wb_rd;
  logic               wb_reg_write;
  isa_pkg::word_t     wb_value;

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + isa_pkg::pc_step;
    end
  end

  assign if_id_d.instruction = instruction;

  pipe_reg #(
    .payload_t (pipe_pkg::if_id_t),
    .on_stall  (pipe_pkg::hold)
  ) if_id_reg (
    .CLOCK (CLOCK),
    .reset (reset),
    .stall (stall),
    .d     (if_id_d),
    .q     (if_id)
  );

  decode_unit decode_unit_inst (
    .instruction (if_id.instruction),
    .ctrl        (id_ctrl),
    .rn          (id_rn),
    .rm          (id_rm),
    .rd          (id_rd),
    .offset      (id_offset)
  );

  register_file register_file_inst (
    .CLOCK        (CLOCK),
    .reset        (reset),
    .read_idx_a   (id_rn),
    .read_idx_b   (id_rm),
    .write_idx    (wb_rd),
    .write_data   (wb_value),
    .write_enable (wb_reg_write),
    .read_data_a  (id_rn_data),
    .read_data_b  (id_rm_data)
  );

  hazard_unit hazard_unit_inst (
    .id_rn         (id_rn),
    .id_rm         (id_rm),
    .ex_rn         (id_ex.rn),
    .ex_rm         (id_ex.rm),
    .ex_rd         (id_ex.rd),
    .ex_mem_read   (id_ex.ctrl.mem_read),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .wb_rd         (wb_rd),
    .wb_reg_write  (wb_reg_write),
    .stall         (stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  assign id_ex_d.ctrl    = id_ctrl;
  assign id_ex_d.rn_data = id_rn_data;
  assign id_ex_d.rm_data = id_rm_data;
  assign id_ex_d.offset  = id_offset;
  assign id_ex_d.rd      = id_rd;
  assign id_ex_d.rn      = id_rn;
  assign id_ex_d.rm      = id_rm;

  pipe_reg #(
    .payload_t (pipe_pkg::id_ex_t),
    .on_stall  (pipe_pkg::bubble)              // Load-use inserts a bubble here
  ) id_ex_reg (
    .CLOCK (CLOCK),
    .reset (reset),
    .stall (stall),
    .d     (id_ex_d),
    .q     (id_ex)
  );

  execute_stage execute_stage_inst (
    .CLOCK          (CLOCK),
    .reset          (reset),
    .id_ex          (id_ex),
    .fwd_a          (fwd_a),
    .fwd_b          (fwd_b),
    .wb_value       (wb_value),
    .mem_address    (mem_address),
    .mem_write_data (mem_write_data),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .mem_rd         (mem_rd),
    .mem_reg_write  (mem_reg_write),
    .mem_to_reg     (mem_to_reg)
  );

  writeback_stage writeback_stage_inst (
    .CLOCK         (CLOCK),
    .reset         (reset),
    .mem_address   (mem_address),
    .mem_read_data (mem_read_data),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .mem_to_reg    (mem_to_reg),
    .wb_rd         (wb_rd),
    .wb_reg_write  (wb_reg_write),
    .wb_value      (wb_value)
  );

  // The bubble in ID/EX clears the load, so a stall cannot repeat
  stall_single_cycle: assert property (@(posedge CLOCK) disable iff (reset)
    stall |=> !stall);

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

  typedef enum logic [1:0] {
    alu_add,       // Zero so a bubble decodes as add
    alu_sub,
    alu_and,
    alu_orr
  } alu_op_t;

  // All zeros is a bubble
  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src;      // Second operand from offset
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef enum logic [1:0] {
    from_reg,
    from_mem,
    from_wb
  } fwd_sel_t;

  typedef struct packed {
    isa_pkg::instr_t instruction;
  } if_id_t;

  typedef struct packed {
    ctrl_t             ctrl;
    isa_pkg::word_t    rn_data;
    isa_pkg::word_t    rm_data;
    isa_pkg::word_t    offset;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rn;  // Source indexes for forwarding
    isa_pkg::reg_idx_t rm;
  } id_ex_t;

  typedef enum logic {
    hold,
    bubble
  } stall_action_t;

endpackage

//--- pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = logic,
  parameter pipe_pkg::stall_action_t on_stall = pipe_pkg::hold
) (
  input  logic     CLOCK,
  input  logic     reset,
  input  logic     stall,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      q <= '0;                               // Zero payload is a bubble
    end else if (stall) begin
      if (on_stall == pipe_pkg::bubble) begin
        q <= '0;
      end                                    // Hold otherwise
    end else begin
      q <= d;
    end
  end

endmodule

//--- register_file.sv
module register_file (
  input  logic              CLOCK,
  input  logic              reset,
  input  isa_pkg::reg_idx_t read_idx_a,
  input  isa_pkg::reg_idx_t read_idx_b,
  input  isa_pkg::reg_idx_t write_idx,
  input  isa_pkg::word_t    write_data,
  input  logic              write_enable,
  output isa_pkg::word_t    read_data_a,
  output isa_pkg::word_t    read_data_b
);

  isa_pkg::word_t regs [32];

  function automatic isa_pkg::word_t read_port(isa_pkg::reg_idx_t idx);
    if (write_enable && write_idx != isa_pkg::zero_reg && idx == write_idx) begin
      return write_data;                      // Write before read bypass
    end
    return regs[idx];                         // XZR storage holds zero
  endfunction

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (i == isa_pkg::zero_reg) ? '0 : isa_pkg::word_t'(i);  // Xi starts at i
      end
    end else if (write_enable && write_idx != isa_pkg::zero_reg) begin
      regs[write_idx] <= write_data;
    end
  end

  always_comb begin
    read_data_a = read_port(read_idx_a);
    read_data_b = read_port(read_idx_b);
  end

  zero_reg_kept: assert property (@(posedge CLOCK) disable iff (reset)
    write_enable |=> regs[isa_pkg::zero_reg] == '0);

endmodule

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_legv8_cpu -f tb.f > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_legv8_cpu > sim.log 2>&1
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- tb.f
isa_pkg.sv
pipe_pkg.sv
pipe_reg.sv
decode_unit.sv
register_file.sv
hazard_unit.sv
execute_stage.sv
writeback_stage.sv
legv8_cpu.sv
tb_legv8_cpu.sv

//--- tb_legv8_cpu.sv
module tb_legv8_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  logic            CLOCK;
  logic            reset;
  isa_pkg::instr_t instruction;
  isa_pkg::word_t  mem_read_data;
  isa_pkg::word_t  pc;
  isa_pkg::word_t  mem_address;
  isa_pkg::word_t  mem_write_data;
  logic            mem_read;
  logic            mem_write;

  isa_pkg::instr_t prog [$];          // Program, one word per pc step
  isa_pkg::word_t  dmem [256];
  isa_pkg::word_t  model_regs [32];
  isa_pkg::word_t  model_mem [256];
  isa_pkg::word_t  exp_addr [$];
  isa_pkg::word_t  exp_data [$];
  isa_pkg::word_t  exp_load [$];      // Load addresses in program order
  isa_pkg::word_t  exp_pc [$];        // Fetch address per cycle after reset

  legv8_cpu legv8_cpu_inst (
    .CLOCK          (CLOCK),
    .reset          (reset),
    .instruction    (instruction),
    .mem_read_data  (mem_read_data),
    .pc             (pc),
    .mem_address    (mem_address),
    .mem_write_data (mem_write_data),
    .mem_read       (mem_read),
    .mem_write      (mem_write)
  );

  initial begin
    CLOCK = 1'b0;
    forever #50 CLOCK = ~CLOCK;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, isa_pkg::word_t expected, isa_pkg::word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("error %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  function automatic isa_pkg::instr_t encode_r(logic [10:0] op, int rd, int rn, int rm);
    return {op, 5'(rm), 6'b0, 5'(rn), 5'(rd)};
  endfunction

  function automatic isa_pkg::instr_t encode_addi(int rd, int rn, int imm);
    return {isa_pkg::opcode_addi, 12'(imm), 5'(rn), 5'(rd)};
  endfunction

  // Loads and stores always use X31 as base
  function automatic isa_pkg::instr_t encode_mem(logic [10:0] op, int rt, int offset);
    return {op, 9'(offset), 2'b00, isa_pkg::zero_reg, 5'(rt)};
  endfunction

  function automatic isa_pkg::instr_t fetch_word(int k);
    if (k >= 0 && k < prog.size()) begin
      return prog[k];
    end
    return '0;                        // Past the end is a bubble
  endfunction

  // Word j is in decode while a load at j-1 is in execute
  function automatic logic load_use(int j);
    isa_pkg::instr_t   prev;
    isa_pkg::instr_t   cur;
    isa_pkg::reg_idx_t src_b;
    if (j < 1) begin
      return 1'b0;
    end
    prev  = fetch_word(j - 1);
    cur   = fetch_word(j);
    src_b = cur[28] ? cur[4:0] : cur[20:16];  // Stores and ADDI read the Rd field
    return prev[31:21] == isa_pkg::opcode_ldur && prev[4:0] != isa_pkg::zero_reg &&
           (prev[4:0] == cur[9:5] || prev[4:0] == src_b);
  endfunction

  task automatic model_step(isa_pkg::instr_t w);
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    addr;
    isa_pkg::word_t    result;
    logic              writes;
    rd     = w[4:0];
    a      = model_regs[w[9:5]];
    b      = model_regs[w[20:16]];
    addr   = a + {{55{w[20]}}, w[20:12]};
    writes = 1'b1;
    result = '0;
    if (w[31:22] == isa_pkg::opcode_addi) begin
      result = a + {52'b0, w[21:10]};
    end else begin
      case (w[31:21])
        isa_pkg::opcode_add:  result = a + b;
        isa_pkg::opcode_sub:  result = a - b;
        isa_pkg::opcode_and:  result = a & b;
        isa_pkg::opcode_orr:  result = a | b;
        isa_pkg::opcode_ldur: begin
          result = model_mem[addr[7:0]];
          exp_load.push_back(addr);
        end
        isa_pkg::opcode_stur: begin
          writes = 1'b0;
          exp_addr.push_back(addr);
          exp_data.push_back(model_regs[rd]);
          model_mem[addr[7:0]] = model_regs[rd];
        end
        default: writes = 1'b0;
      endcase
    end
    if (writes && rd != isa_pkg::zero_reg) begin
      model_regs[rd] = result;        // X31 is never written
    end
  endtask

  task automatic run_model();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = (i == 31) ? '0 : isa_pkg::word_t'(i);
    end
    for (int a = 0; a < 256; a++) begin
      model_mem[a] = isa_pkg::word_t'(a * 5);
    end
    exp_addr.delete();
    exp_data.delete();
    exp_load.delete();
    exp_pc.delete();
    foreach (prog[k]) begin
      model_step(prog[k]);
    end
    for (int k = 0; k <= prog.size() + 4; k++) begin
      exp_pc.push_back(isa_pkg::word_t'(4 * k));
      if (load_use(k - 1)) begin
        exp_pc.push_back(isa_pkg::word_t'(4 * k));  // Held one cycle
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge CLOCK);
    #5;
    instruction   = fetch_word(int'(pc >> 2));
    mem_read_data = dmem[mem_address[7:0]];
  endtask

  task automatic apply_reset(string name);
    reset = 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(negedge CLOCK);
      check_bit({name, " mem_read in reset"}, 1'b0, mem_read);
      check_bit({name, " mem_write in reset"}, 1'b0, mem_write);
      next_cycle();
    end
    reset = 1'b0;
  endtask

  task automatic run_test(string name);
    isa_pkg::word_t end_pc;
    int             cycles;
    int             limit;
    logic           done;
    run_model();
    for (int a = 0; a < 256; a++) begin
      dmem[a] = isa_pkg::word_t'(a * 5);
    end
    apply_reset(name);
    end_pc  = isa_pkg::word_t'(4 * (prog.size() + 4));  // Last word has left MEM
    limit   = 2 * prog.size() + 40;
    cycles  = 0;
    done    = 1'b0;
    while (!done) begin
      @(negedge CLOCK);
      if (exp_pc.size() > 0) begin
        check_word({name, " pc"}, exp_pc.pop_front(), pc);
      end
      if (cycles < 3) begin
        check_bit({name, " mem_read after reset"}, 1'b0, mem_read);
        check_bit({name, " mem_write after reset"}, 1'b0, mem_write);
      end
      if (mem_read) begin
        if (exp_load.size() == 0) begin
          report_failure({name, ": the CPU made a load that the program does not make"});
        end
        check_word({name, " load address"}, exp_load.pop_front(), mem_address);
      end
      if (mem_write) begin
        if (exp_addr.size() == 0) begin
          report_failure({name, ": the CPU made a store that the program does not make"});
        end
        check_word({name, " store address"}, exp_addr.pop_front(), mem_address);
        check_word({name, " store data"}, exp_data.pop_front(), mem_write_data);
        dmem[mem_address[7:0]] = mem_write_data;
      end
      done = exp_addr.size() == 0 && exp_load.size() == 0 && pc >= end_pc;
      if (!done && cycles >= limit) begin
        report_failure($sformatf("%s: loads and stores did not all arrive within %0d cycles",
                                 name, limit));
      end
      next_cycle();
      cycles++;
    end
    $display("%s: %0d cycles", name, cycles);
  endtask

  task automatic build_reset_program();
    prog.delete();
    prog.push_back(encode_addi(1, 31, 11));
    prog.push_back(encode_addi(2, 31, 22));
    prog.push_back(encode_r(isa_pkg::opcode_add, 3, 4, 5));
    prog.push_back(encode_r(isa_pkg::opcode_orr, 6, 7, 0));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 3, 3));
  endtask

  task automatic build_alu_program();
    prog.delete();
    prog.push_back(encode_r(isa_pkg::opcode_add, 1, 2, 3));
    prog.push_back(encode_r(isa_pkg::opcode_sub, 4, 2, 7));  // Negative result
    prog.push_back(encode_r(isa_pkg::opcode_and, 5, 6, 3));
    prog.push_back(encode_r(isa_pkg::opcode_orr, 6, 4, 1));
    prog.push_back(encode_addi(7, 7, 100));
    for (int r = 1; r <= 7; r++) begin
      prog.push_back(encode_mem(isa_pkg::opcode_stur, r, 8 * r));
    end
  endtask

  task automatic build_forward_program();
    prog.delete();
    prog.push_back(encode_r(isa_pkg::opcode_add, 1, 2, 3));
    prog.push_back(encode_r(isa_pkg::opcode_add, 1, 1, 1));  // Distance 1
    prog.push_back(encode_r(isa_pkg::opcode_sub, 6, 1, 2));  // X1 in MEM and WB
    prog.push_back(encode_addi(3, 4, 1));
    prog.push_back(encode_r(isa_pkg::opcode_orr, 7, 1, 6));  // Distances 3 and 2
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 6, 48));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 7, 56));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 1, 64));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 3, 72));
  endtask

  task automatic build_load_use_program();
    prog.delete();
    prog.push_back(encode_mem(isa_pkg::opcode_ldur, 1, 10));
    prog.push_back(encode_r(isa_pkg::opcode_add, 2, 1, 1));  // Stalls
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 2, 0));
    prog.push_back(encode_mem(isa_pkg::opcode_ldur, 3, 0));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 3, 1));  // Store data stalls
    prog.push_back(encode_mem(isa_pkg::opcode_ldur, 4, 20));
    prog.push_back(encode_addi(5, 31, 3));
    prog.push_back(encode_r(isa_pkg::opcode_sub, 6, 4, 5));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 6, 2));
  endtask

  task automatic build_zero_reg_program();
    prog.delete();
    prog.push_back(encode_addi(31, 2, 77));
    prog.push_back(encode_r(isa_pkg::opcode_add, 31, 3, 4));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 31, 5));
    prog.push_back(encode_r(isa_pkg::opcode_orr, 1, 31, 31));
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 1, 6));
    prog.push_back(encode_mem(isa_pkg::opcode_ldur, 31, 7));
    prog.push_back(encode_r(isa_pkg::opcode_add, 2, 31, 3));  // No stall on X31
    prog.push_back(encode_mem(isa_pkg::opcode_stur, 2, 9));
  endtask

  function automatic int random_reg();
    int r;
    r = $urandom_range(0, 8);
    return (r == 8) ? 31 : r;
  endfunction

  task automatic build_random_program(int count);
    logic [10:0] r_ops [4];
    int          kind;
    r_ops = '{isa_pkg::opcode_add, isa_pkg::opcode_sub, isa_pkg::opcode_and,
              isa_pkg::opcode_orr};
    prog.delete();
    for (int i = 0; i < count; i++) begin
      kind = $urandom_range(0, 6);
      if (kind < 4) begin
        prog.push_back(encode_r(r_ops[kind], random_reg(), random_reg(), random_reg()));
      end else if (kind == 4) begin
        prog.push_back(encode_addi(random_reg(), random_reg(), $urandom_range(0, 4095)));
      end else if (kind == 5) begin
        prog.push_back(encode_mem(isa_pkg::opcode_ldur, random_reg(), $urandom_range(0, 255)));
      end else begin
        prog.push_back(encode_mem(isa_pkg::opcode_stur, random_reg(), $urandom_range(0, 255)));
      end
    end
  endtask

  initial begin
    void'($urandom(32'h25b0f34d));
    reset         = 1'b1;
    instruction   = '0;
    mem_read_data = '0;
    next_cycle();
    build_reset_program();
    run_test("reset");
    build_alu_program();
    run_test("alu");
    build_forward_program();
    run_test("forwarding");
    build_load_use_program();
    run_test("load_use");
    build_zero_reg_program();
    run_test("zero_reg");
    build_random_program(200);
    run_test("random");
    $display("Everything OK");
    $finish;
  end

endmodule

//--- writeback_stage.sv
module writeback_stage (
  input  logic              CLOCK,
  input  logic              reset,
  input  isa_pkg::word_t    mem_address,
  input  isa_pkg::word_t    mem_read_data,
  input  isa_pkg::reg_idx_t mem_rd,
  input  logic              mem_reg_write,
  input  logic              mem_to_reg,
  output isa_pkg::reg_idx_t wb_rd,
  output logic              wb_reg_write,
  output isa_pkg::word_t    wb_value
);

  isa_pkg::word_t wb_alu_result;
  isa_pkg::word_t wb_load_data;
  logic           wb_to_reg;

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
    end
  end

  always_ff @(posedge CLOCK) begin
    wb_rd         <= mem_rd;
    wb_to_reg     <= mem_to_reg;
    wb_alu_result <= mem_address;              // ALU result rides the address bus
    wb_load_data  <= mem_read_data;
  end

  assign wb_value = wb_to_reg ? wb_load_data : wb_alu_result;

endmodule
